// File: scope_pkg.sv
// Shared widths, register map and reset defaults of the capture engine.
// The buffer depth is fixed here. Both RAMs hold 2**RSZ samples.
package scope_pkg;

   localparam int SMP_W = 14;                  // ADC sample width
   localparam int ACC_W = 32;                  // window sum width
   localparam int RSZ   = 10;                  // log2 of buffer depth
   localparam int DEC_W = 17;
   localparam int SHF_W = 5;
   localparam int DLY_W = 32;
   localparam int RD_LAT = 4;                  // strobe to ack, buffer reads

   typedef logic signed [SMP_W-1:0] sample_t;
   typedef logic signed [ACC_W-1:0] acc_t;
   typedef logic        [RSZ-1:0]   ptr_t;

   // ------------------------------------------------------------------
   // register offsets, address bits 19:0
   localparam logic [19:0] REG_ARM      = 20'h00;
   localparam logic [19:0] REG_TRIG_SRC = 20'h04;
   localparam logic [19:0] REG_THR_A    = 20'h08;
   localparam logic [19:0] REG_THR_B    = 20'h0C;
   localparam logic [19:0] REG_POST_DLY = 20'h10;
   localparam logic [19:0] REG_DEC      = 20'h14;
   localparam logic [19:0] REG_WP_CUR   = 20'h18;
   localparam logic [19:0] REG_WP_TRIG  = 20'h1C;
   localparam logic [19:0] REG_HYST_A   = 20'h20;
   localparam logic [19:0] REG_HYST_B   = 20'h24;
   localparam logic [19:0] REG_AVG_EN   = 20'h28;
   localparam logic [19:0] REG_DEC_SHF  = 20'h98;
   localparam logic [3:0]  BUF_A_REGION = 4'h1;  // address bits 19:16
   localparam logic [3:0]  BUF_B_REGION = 4'h2;

   typedef enum logic [3:0] {
      SRC_NONE  = 4'd0,
      SRC_SW    = 4'd1,
      SRC_A_POS = 4'd2,
      SRC_A_NEG = 4'd3,
      SRC_B_POS = 4'd4,
      SRC_B_NEG = 4'd5
   } trig_src_t;

   // ------------------------------------------------------------------
   // reset defaults
   localparam sample_t           RST_THR_A    = 14'sd5000;
   localparam sample_t           RST_THR_B    = -14'sd5000;
   localparam sample_t           RST_HYST     = 14'sd20;
   localparam logic [DEC_W-1:0]  RST_DEC      = 17'd1;
   localparam logic              RST_AVG_EN   = 1'b1;
   localparam logic [SHF_W-1:0]  RST_DEC_SHF  = 5'd0;
   localparam logic [DLY_W-1:0]  RST_POST_DLY = 32'd0;

endpackage

// File: scope_regs.sv
// Register bank on the plain strobe bus. No back-pressure.
// Register reads ack one cycle after the strobe, buffer reads RD_LAT cycles.
// Only one read may be in flight, the buffer select is latched at the strobe.
`timescale 1ns/100ps
module scope_regs import scope_pkg::*; (
   input  logic             adc_clk_i,
   input  logic             adc_rstn_i,
   input  logic [31:0]      sys_addr_i,
   input  logic [31:0]      sys_wdata_i,
   input  logic             sys_wen_i,
   input  logic             sys_ren_i,
   input  logic             writing_i,
   input  logic             delaying_i,
   input  ptr_t             wp_cur_i,
   input  ptr_t             wp_trig_i,
   input  sample_t          rd_a_i,
   input  sample_t          rd_b_i,
   input  logic             done_i,
   output logic [31:0]      sys_rdata_o,
   output logic             sys_ack_o,
   output logic             arm_o,
   output logic             rst_o,
   output logic             sw_trig_o,
   output trig_src_t        src_o,
   output sample_t          thr_a_o,
   output sample_t          thr_b_o,
   output sample_t          hyst_a_o,
   output sample_t          hyst_b_o,
   output logic [DEC_W-1:0] dec_o,
   output logic [SHF_W-1:0] dec_shf_o,
   output logic             avg_en_o,
   output logic [DLY_W-1:0] post_dly_o,
   output ptr_t             rd_addr_o
);

   logic [19:0]       addr;
   logic              buf_rd;          // strobe hits a buffer region
   logic [RD_LAT-2:0] rd_sr;           // last stage is sys_ack_o itself
   logic              rd_sel_b;
   logic [31:0]       reg_rdata;

   assign addr      = sys_addr_i[19:0];
   assign buf_rd    = (addr[19:16] == BUF_A_REGION) || (addr[19:16] == BUF_B_REGION);
   assign rd_addr_o = sys_addr_i[RSZ+1:2];

   // ------------------------------------------------------------------
   // settings and command pulses
   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         arm_o      <= 1'b0;
         rst_o      <= 1'b0;
         sw_trig_o  <= 1'b0;
         src_o      <= SRC_NONE;
         thr_a_o    <= RST_THR_A;
         thr_b_o    <= RST_THR_B;
         hyst_a_o   <= RST_HYST;
         hyst_b_o   <= RST_HYST;
         dec_o      <= RST_DEC;
         dec_shf_o  <= RST_DEC_SHF;
         avg_en_o   <= RST_AVG_EN;
         post_dly_o <= RST_POST_DLY;
      end else begin
         arm_o     <= sys_wen_i && (addr == REG_ARM) && sys_wdata_i[0];
         rst_o     <= sys_wen_i && (addr == REG_ARM) && sys_wdata_i[1];
         sw_trig_o <= sys_wen_i && (addr == REG_TRIG_SRC) && (sys_wdata_i[3:0] == SRC_SW);

         if (sys_wen_i && (addr == REG_TRIG_SRC))
            src_o <= trig_src_t'(sys_wdata_i[3:0]);
         else if (done_i || rst_o)            // capture over, source disarms
            src_o <= SRC_NONE;

         if (sys_wen_i) begin
            case (addr)
               REG_THR_A:    thr_a_o    <= sys_wdata_i[SMP_W-1:0];
               REG_THR_B:    thr_b_o    <= sys_wdata_i[SMP_W-1:0];
               REG_HYST_A:   hyst_a_o   <= sys_wdata_i[SMP_W-1:0];
               REG_HYST_B:   hyst_b_o   <= sys_wdata_i[SMP_W-1:0];
               REG_DEC:      dec_o      <= sys_wdata_i[DEC_W-1:0];
               REG_DEC_SHF:  dec_shf_o  <= sys_wdata_i[SHF_W-1:0];
               REG_AVG_EN:   avg_en_o   <= sys_wdata_i[0];
               REG_POST_DLY: post_dly_o <= sys_wdata_i[DLY_W-1:0];
               default: ;
            endcase
         end
      end
   end

   // ------------------------------------------------------------------
   // read mux, values zero extended
   always_comb begin
      reg_rdata = '0;
      case (addr)
         REG_ARM:      reg_rdata[1:0]       = {delaying_i, writing_i};
         REG_TRIG_SRC: reg_rdata[3:0]       = src_o;
         REG_THR_A:    reg_rdata[SMP_W-1:0] = thr_a_o;
         REG_THR_B:    reg_rdata[SMP_W-1:0] = thr_b_o;
         REG_HYST_A:   reg_rdata[SMP_W-1:0] = hyst_a_o;
         REG_HYST_B:   reg_rdata[SMP_W-1:0] = hyst_b_o;
         REG_DEC:      reg_rdata[DEC_W-1:0] = dec_o;
         REG_DEC_SHF:  reg_rdata[SHF_W-1:0] = dec_shf_o;
         REG_AVG_EN:   reg_rdata[0]         = avg_en_o;
         REG_POST_DLY: reg_rdata            = post_dly_o;
         REG_WP_CUR:   reg_rdata[RSZ-1:0]   = wp_cur_i;
         REG_WP_TRIG:  reg_rdata[RSZ-1:0]   = wp_trig_i;
         default: ;
      endcase
   end

   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         rd_sr     <= '0;
         sys_ack_o <= 1'b0;
      end else begin
         rd_sr     <= {rd_sr[RD_LAT-3:0], sys_ren_i && buf_rd};
         sys_ack_o <= (sys_ren_i && !buf_rd) || rd_sr[RD_LAT-2];
      end
   end

   always_ff @(posedge adc_clk_i) begin
      if (sys_ren_i)
         rd_sel_b <= (addr[19:16] == BUF_B_REGION);
      if (rd_sr[RD_LAT-2])                     // RAM data arrives here
         sys_rdata_o <= rd_sel_b ? 32'(rd_b_i) : 32'(rd_a_i);
      else
         sys_rdata_o <= reg_rdata;
   end

   // a single strobe gets a single-cycle ack
   a_ack_once: assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
      sys_ack_o |=> !sys_ack_o);

endmodule

// File: dec_avg.sv
// Decimation and averaging of both channels.
// The average is the window sum shifted right, so shift = log2(dec)
// gives the mean. With dec = 1 a sample comes out every cycle.
`timescale 1ns/100ps
module dec_avg import scope_pkg::*; (
   input  logic             adc_clk_i,
   input  logic             adc_rstn_i,
   input  sample_t          adc_a_i,
   input  sample_t          adc_b_i,
   input  logic [DEC_W-1:0] dec_i,
   input  logic [SHF_W-1:0] dec_shf_i,
   input  logic             avg_en_i,
   input  logic             arm_i,
   output logic             dv_o,
   output sample_t          dat_a_o,
   output sample_t          dat_b_o
);

   logic [DEC_W-1:0] cnt;
   acc_t             sum_a;
   acc_t             sum_b;
   acc_t             avg_a;
   acc_t             avg_b;

   assign avg_a = sum_a >>> dec_shf_i;
   assign avg_b = sum_b >>> dec_shf_i;

   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         cnt   <= '0;
         sum_a <= '0;
         sum_b <= '0;
         dv_o  <= 1'b0;
      end else begin
         if ((cnt >= dec_i) || arm_i) begin   // window end or restart
            cnt   <= DEC_W'(1);
            sum_a <= acc_t'(adc_a_i);
            sum_b <= acc_t'(adc_b_i);
         end else begin
            cnt   <= cnt + DEC_W'(1);
            sum_a <= sum_a + acc_t'(adc_a_i);
            sum_b <= sum_b + acc_t'(adc_b_i);
         end
         dv_o <= (cnt >= dec_i);
      end
   end

   // output samples, old sum is the finished window
   always_ff @(posedge adc_clk_i) begin
      dat_a_o <= avg_en_i ? avg_a[SMP_W-1:0] : adc_a_i;
      dat_b_o <= avg_en_i ? avg_b[SMP_W-1:0] : adc_b_i;
   end

endmodule

// File: level_trig.sv
// Schmitt level trigger for one channel.
// Pulses come two cycles after the crossing sample. Threshold changes
// reach the lower and upper hysteresis limits one cycle later.
`timescale 1ns/100ps
module level_trig import scope_pkg::*; (
   input  logic    adc_clk_i,
   input  logic    adc_rstn_i,
   input  logic    dv_i,
   input  sample_t dat_i,
   input  sample_t thr_i,
   input  sample_t hyst_i,
   output logic    pos_o,
   output logic    neg_o
);

   logic signed [SMP_W:0] thr_lo;      // one extra bit, no overflow
   logic signed [SMP_W:0] thr_hi;
   logic [1:0]            st_pos;      // [0] state, [1] delayed copy
   logic [1:0]            st_neg;

   always_ff @(posedge adc_clk_i) begin
      thr_lo <= thr_i - hyst_i;
      thr_hi <= thr_i + hyst_i;
   end

   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         st_pos <= 2'b00;
         st_neg <= 2'b00;
         pos_o  <= 1'b0;
         neg_o  <= 1'b0;
      end else begin
         if (dv_i) begin
            if (dat_i >= thr_i)
               st_pos[0] <= 1'b1;
            else if (dat_i < thr_lo)
               st_pos[0] <= 1'b0;      // rearm below hysteresis
            if (dat_i <= thr_i)
               st_neg[0] <= 1'b1;
            else if (dat_i > thr_hi)
               st_neg[0] <= 1'b0;
         end
         st_pos[1] <= st_pos[0];
         st_neg[1] <= st_neg[0];
         pos_o     <= st_pos[0] && !st_pos[1];
         neg_o     <= st_neg[0] && !st_neg[1];
      end
   end

endmodule

// File: acq_fsm.sv
// Acquisition control: idle, armed, post-trigger delay.
// The trigger cycle sample lands at the trigger pointer and the delay
// count of samples follows it. No sample is written once the count is zero.
`timescale 1ns/100ps
module acq_fsm import scope_pkg::*; (
   input  logic      adc_clk_i,
   input  logic      adc_rstn_i,
   input  logic      arm_i,
   input  logic      rst_i,
   input  logic      sw_trig_i,
   input  trig_src_t src_i,
   input  logic      a_pos_i,
   input  logic      a_neg_i,
   input  logic      b_pos_i,
   input  logic      b_neg_i,
   input  logic      dv_i,
   input  logic      dly_zero_i,
   output logic      we_o,
   output logic      trig_o,
   output logic      run_dly_o,
   output logic      done_o,
   output logic      writing_o
);

   typedef enum logic [1:0] {IDLE, ARMED, DELAY} state_t;

   state_t state;
   logic   sel_trig;

   always_comb begin
      case (src_i)
         SRC_SW:    sel_trig = sw_trig_i;
         SRC_A_POS: sel_trig = a_pos_i;
         SRC_A_NEG: sel_trig = a_neg_i;
         SRC_B_POS: sel_trig = b_pos_i;
         SRC_B_NEG: sel_trig = b_neg_i;
         default:   sel_trig = 1'b0;
      endcase
   end

   assign writing_o = (state != IDLE);
   assign run_dly_o = (state == DELAY);
   assign we_o      = writing_o && dv_i && !(run_dly_o && dly_zero_i);

   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         state  <= IDLE;
         trig_o <= 1'b0;
         done_o <= 1'b0;
      end else begin
         trig_o <= sel_trig && (state == ARMED);
         done_o <= 1'b0;
         if (rst_i) begin
            state <= IDLE;
         end else if (arm_i) begin
            state <= ARMED;
         end else begin
            case (state)
               ARMED: if (trig_o) begin
                  if (dly_zero_i) begin  // no delay, end at once
                     state  <= IDLE;
                     done_o <= 1'b1;
                  end else begin
                     state <= DELAY;
                  end
               end
               DELAY: if (dly_zero_i) begin
                  state  <= IDLE;
                  done_o <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

endmodule

// File: post_dly_cnt.sv
// Post-trigger sample countdown.
// Counts written samples, not clock cycles.
`timescale 1ns/100ps
module post_dly_cnt import scope_pkg::*; (
   input  logic             adc_clk_i,
   input  logic             adc_rstn_i,
   input  logic [DLY_W-1:0] post_dly_i,
   input  logic             run_i,
   input  logic             we_i,
   output logic             zero_o
);

   logic [DLY_W-1:0] cnt;

   assign zero_o = (cnt == '0);

   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i)
         cnt <= '0;
      else if (!run_i)
         cnt <= post_dly_i;              // reload while not delaying
      else if (we_i)
         cnt <= cnt - DLY_W'(1);
   end

   // writes stop at zero in the FSM
   a_no_wrap: assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
      (run_i && we_i) |-> !zero_o);

endmodule

// File: capture_buf.sv
// Circular sample buffers for both channels with write and trigger pointers.
// Read data appears three cycles after the read address.
`timescale 1ns/100ps
module capture_buf import scope_pkg::*; (
   input  logic    adc_clk_i,
   input  logic    adc_rstn_i,
   input  logic    we_i,
   input  logic    rst_i,
   input  logic    trig_i,
   input  logic    delaying_i,
   input  sample_t dat_a_i,
   input  sample_t dat_b_i,
   input  ptr_t    rd_addr_i,
   output sample_t rd_a_o,
   output sample_t rd_b_o,
   output ptr_t    wp_cur_o,
   output ptr_t    wp_trig_o
);

   sample_t mem_a [0:(1<<RSZ)-1];
   sample_t mem_b [0:(1<<RSZ)-1];
   ptr_t    wp;
   ptr_t    raddr_q;
   ptr_t    raddr_qq;

   // ------------------------------------------------------------------
   // write side
   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i || rst_i) begin
         wp        <= '0;
         wp_cur_o  <= '0;
         wp_trig_o <= '0;
      end else begin
         if (we_i) begin
            wp       <= wp + 1'b1;
            wp_cur_o <= wp;
         end
         if (trig_i && !delaying_i)
            wp_trig_o <= we_i ? wp : wp_cur_o;   // trigger sample itself
      end
   end

   always_ff @(posedge adc_clk_i) begin
      if (we_i) begin
         mem_a[wp] <= dat_a_i;
         mem_b[wp] <= dat_b_i;
      end
   end

   // ------------------------------------------------------------------
   // read side
   always_ff @(posedge adc_clk_i) begin
      raddr_q  <= rd_addr_i;
      raddr_qq <= raddr_q;
      rd_a_o   <= mem_a[raddr_qq];
      rd_b_o   <= mem_b[raddr_qq];
   end

endmodule

// File: scope_top.sv
// Two-channel capture engine, ADC samples in, register bus out.
// Single clock domain. ADC data is taken on every cycle.
`timescale 1ns/100ps
module scope_top import scope_pkg::*; (
   input  logic        adc_clk_i,
   input  logic        adc_rstn_i,
   input  sample_t     adc_a_i,
   input  sample_t     adc_b_i,
   input  logic [31:0] sys_addr_i,
   input  logic [31:0] sys_wdata_i,
   input  logic        sys_wen_i,
   input  logic        sys_ren_i,
   output logic [31:0] sys_rdata_o,
   output logic        sys_ack_o
);

   logic             arm, rst, sw_trig, done, writing, delaying;
   trig_src_t        src;
   sample_t          thr_a, thr_b, hyst_a, hyst_b;
   logic [DEC_W-1:0] dec;
   logic [SHF_W-1:0] dec_shf;
   logic             avg_en;
   logic [DLY_W-1:0] post_dly;
   ptr_t             rd_addr, wp_cur, wp_trig;
   sample_t          rd_a, rd_b, dat_a, dat_b;
   logic             dv, we, trig, dly_zero;
   logic             a_pos, a_neg, b_pos, b_neg;

   scope_regs u_regs (
      .adc_clk_i, .adc_rstn_i,
      .sys_addr_i, .sys_wdata_i, .sys_wen_i, .sys_ren_i,
      .writing_i(writing), .delaying_i(delaying),
      .wp_cur_i(wp_cur), .wp_trig_i(wp_trig),
      .rd_a_i(rd_a), .rd_b_i(rd_b), .done_i(done),
      .sys_rdata_o, .sys_ack_o,
      .arm_o(arm), .rst_o(rst), .sw_trig_o(sw_trig), .src_o(src),
      .thr_a_o(thr_a), .thr_b_o(thr_b), .hyst_a_o(hyst_a), .hyst_b_o(hyst_b),
      .dec_o(dec), .dec_shf_o(dec_shf), .avg_en_o(avg_en),
      .post_dly_o(post_dly), .rd_addr_o(rd_addr)
   );

   dec_avg u_dec (
      .adc_clk_i, .adc_rstn_i, .adc_a_i, .adc_b_i,
      .dec_i(dec), .dec_shf_i(dec_shf), .avg_en_i(avg_en), .arm_i(arm),
      .dv_o(dv), .dat_a_o(dat_a), .dat_b_o(dat_b)
   );

   level_trig u_lvl_a (
      .adc_clk_i, .adc_rstn_i, .dv_i(dv), .dat_i(dat_a),
      .thr_i(thr_a), .hyst_i(hyst_a), .pos_o(a_pos), .neg_o(a_neg)
   );

   level_trig u_lvl_b (
      .adc_clk_i, .adc_rstn_i, .dv_i(dv), .dat_i(dat_b),
      .thr_i(thr_b), .hyst_i(hyst_b), .pos_o(b_pos), .neg_o(b_neg)
   );

   acq_fsm u_fsm (
      .adc_clk_i, .adc_rstn_i, .arm_i(arm), .rst_i(rst), .sw_trig_i(sw_trig),
      .src_i(src), .a_pos_i(a_pos), .a_neg_i(a_neg), .b_pos_i(b_pos), .b_neg_i(b_neg),
      .dv_i(dv), .dly_zero_i(dly_zero),
      .we_o(we), .trig_o(trig), .run_dly_o(delaying), .done_o(done), .writing_o(writing)
   );

   post_dly_cnt u_dly (
      .adc_clk_i, .adc_rstn_i, .post_dly_i(post_dly),
      .run_i(delaying), .we_i(we), .zero_o(dly_zero)
   );

   capture_buf u_buf (
      .adc_clk_i, .adc_rstn_i, .we_i(we), .rst_i(rst),
      .trig_i(trig), .delaying_i(delaying),
      .dat_a_i(dat_a), .dat_b_i(dat_b), .rd_addr_i(rd_addr),
      .rd_a_o(rd_a), .rd_b_o(rd_b), .wp_cur_o(wp_cur), .wp_trig_o(wp_trig)
   );

endmodule

// File: tb_scope.sv
// Self-checking testbench for the two-channel capture engine.
// ADC inputs are ramps, channel B is the negated channel A ramp.
// Bus outputs are sampled on the falling clock edge.
// The ramp start of each test is chosen so that no ramp wraps during an average.
`timescale 1ns/100ps
module tb_scope import scope_pkg::*; ();

   localparam logic [31:0] LFSR_POLY = 32'h80200003;
   localparam int          PTR_MASK  = (1 << RSZ) - 1;
   localparam int          MAX_CYC   = 6 * 4 * (2 * (1 << RSZ)) + 1000;  // six tests plus margin
   localparam int          ACK_WAIT  = 16;

   logic        clk = 1'b0;
   logic        rstn = 1'b0;
   sample_t     adc_a = '0;
   sample_t     adc_b = '0;
   logic [31:0] sys_addr = '0;
   logic [31:0] sys_wdata = '0;
   logic        sys_wen = 1'b0;
   logic        sys_ren = 1'b0;
   logic [31:0] sys_rdata;
   logic        sys_ack;

   logic [31:0] lfsr = 32'h13ae6c63;
   sample_t     ramp_start = '0;
   logic        ramp_load = 1'b0;
   int          cyc = 0;
   int          checks = 0;
   int          errors = 0;
   int          chk_mark = 0;
   int          err_mark = 0;

   scope_top uut (
      .adc_clk_i(clk), .adc_rstn_i(rstn), .adc_a_i(adc_a), .adc_b_i(adc_b),
      .sys_addr_i(sys_addr), .sys_wdata_i(sys_wdata), .sys_wen_i(sys_wen),
      .sys_ren_i(sys_ren), .sys_rdata_o(sys_rdata), .sys_ack_o(sys_ack)
   );

   initial begin
      forever #2 clk = ~clk;
   end

   // ramp source, reloaded on request
   always @(posedge clk) begin
      if (ramp_load) begin
         adc_a <= ramp_start;
         adc_b <= -ramp_start;
      end else begin
         adc_a <= adc_a + 14'sd1;
         adc_b <= -(adc_a + 14'sd1);
      end
   end

   initial begin
      while (cyc < MAX_CYC) begin
         @(posedge clk);
         cyc++;
      end
      $display("Timeout after %0d cycles, the tests did not finish", cyc);
      $display("Simulation failed");
      $finish;
   end

   // ------------------------------------------------------------------
   // helpers
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};             // one step per bit
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic logic [31:0] nearest_in(input int v, input int lo, input int hi);
      if (v < lo)
         return 32'(lo);
      if (v > hi)
         return 32'(hi);
      return 32'(v);
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Error: %s expected %0h actual %0h", what, exp, act);
      end
   endtask

   task automatic report_test(input string name);
      $display("%s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
      chk_mark = checks;
      err_mark = errors;
   endtask

   task automatic bus_write(input logic [19:0] offs, input logic [31:0] data);
      @(posedge clk);
      sys_addr  <= {12'h0, offs};
      sys_wdata <= data;
      sys_wen   <= 1'b1;
      @(posedge clk);
      sys_wen   <= 1'b0;
   endtask

   // latency counts cycles from the strobe cycle to the ack cycle
   task automatic bus_read(input logic [31:0] addr, output logic [31:0] data, output int lat);
      @(posedge clk);
      sys_addr <= addr;
      sys_ren  <= 1'b1;
      @(posedge clk);
      sys_ren  <= 1'b0;
      lat = 1;
      @(negedge clk);
      while (!sys_ack && lat < ACK_WAIT) begin
         @(negedge clk);
         lat++;
      end
      if (!sys_ack) begin
         errors++;
         $display("No acknowledge came for the bus read at address %h", addr);
      end
      data = sys_rdata;
   endtask

   task automatic read_and_check(input string what, input logic [19:0] offs,
                                 input logic [31:0] exp);
      logic [31:0] rd;
      int          lat;
      bus_read({12'h0, offs}, rd, lat);
      check_value({what, " ack latency"}, 32'd1, 32'(lat));
      check_value(what, exp, rd);
   endtask

   task automatic read_buf(input logic [3:0] region, input ptr_t ptr, output sample_t val);
      logic [31:0] rd;
      int          lat;
      bus_read({12'h0, region, 16'h0} | (32'(ptr) << 2), rd, lat);
      check_value("buffer ack latency", 32'(RD_LAT), 32'(lat));
      val = rd[SMP_W-1:0];
   endtask

   task automatic load_ramp(input sample_t start);
      @(posedge clk);
      ramp_start <= start;
      ramp_load  <= 1'b1;
      @(posedge clk);
      ramp_load  <= 1'b0;
   endtask

   task automatic wait_capture_end(output logic saw_dly);
      logic [31:0] rd;
      int          lat;
      saw_dly = 1'b0;
      rd      = 32'd1;
      while (rd[0]) begin                       // status bit 0 is writing
         bus_read({12'h0, REG_ARM}, rd, lat);
         if (rd[1])
            saw_dly = 1'b1;
      end
   endtask

   // eight entries ending at last, neighbors step by a fixed amount
   task automatic check_run(input string name, input ptr_t last, input int step,
                            input logic with_b);
      sample_t     cur;
      sample_t     prev;
      sample_t     bv;
      logic [13:0] d;
      prev = '0;
      for (int i = 0; i < 8; i++) begin
         read_buf(BUF_A_REGION, ptr_t'(last - ptr_t'(7 - i)), cur);
         if (i > 0) begin
            d = cur - prev;
            check_value({name, " step"}, 32'(step), {18'd0, d});
         end
         if (with_b) begin
            read_buf(BUF_B_REGION, ptr_t'(last - ptr_t'(7 - i)), bv);
            d = cur + bv;
            check_value({name, " B is minus A"}, 32'd0, {18'd0, d});
         end
         prev = cur;
      end
   endtask

   // ------------------------------------------------------------------
   // tests
   initial begin
      logic [31:0] v;
      logic [31:0] wpc;
      logic [31:0] wpt;
      logic        saw;
      int          lat;
      int          n_dly;
      int          t0;
      sample_t     thr;
      sample_t     ent;

      repeat (3) @(posedge clk);
      rstn <= 1'b1;

      read_and_check("t1 status", REG_ARM, 32'd0);
      read_and_check("t1 source", REG_TRIG_SRC, 32'd0);
      read_and_check("t1 thr_a", REG_THR_A, 32'd5000);
      read_and_check("t1 thr_b", REG_THR_B, 32'(-5000) & 32'h3fff);
      read_and_check("t1 hyst_a", REG_HYST_A, 32'd20);
      read_and_check("t1 hyst_b", REG_HYST_B, 32'd20);
      read_and_check("t1 dec", REG_DEC, 32'd1);
      read_and_check("t1 avg_en", REG_AVG_EN, 32'd1);
      read_and_check("t1 dec_shf", REG_DEC_SHF, 32'd0);
      read_and_check("t1 post_dly", REG_POST_DLY, 32'd0);
      v = rand_bits(32);
      bus_write(REG_THR_A, v);
      read_and_check("t1 thr_a rw", REG_THR_A, v & 32'h3fff);
      v = rand_bits(32);
      bus_write(REG_THR_B, v);
      read_and_check("t1 thr_b rw", REG_THR_B, v & 32'h3fff);
      v = rand_bits(32);
      bus_write(REG_HYST_A, v);
      read_and_check("t1 hyst_a rw", REG_HYST_A, v & 32'h3fff);
      v = rand_bits(32);
      bus_write(REG_HYST_B, v);
      read_and_check("t1 hyst_b rw", REG_HYST_B, v & 32'h3fff);
      v = rand_bits(32);
      bus_write(REG_DEC, v);
      read_and_check("t1 dec rw", REG_DEC, v & 32'h1ffff);
      v = rand_bits(32);
      bus_write(REG_DEC_SHF, v);
      read_and_check("t1 dec_shf rw", REG_DEC_SHF, v & 32'h1f);
      v = rand_bits(32);
      bus_write(REG_AVG_EN, v);
      read_and_check("t1 avg_en rw", REG_AVG_EN, v & 32'h1);
      v = rand_bits(32);
      bus_write(REG_POST_DLY, v);
      read_and_check("t1 post_dly rw", REG_POST_DLY, v);
      report_test("t1 reset and readback");

      bus_write(REG_DEC, 32'd1);
      bus_write(REG_AVG_EN, 32'd0);
      n_dly = 16 + int'(rand_bits(9));
      bus_write(REG_POST_DLY, 32'(n_dly));
      bus_write(REG_ARM, 32'd1);
      bus_write(REG_TRIG_SRC, 32'(SRC_SW));
      wait_capture_end(saw);
      check_value("t2 delaying seen", 32'd1, {31'd0, saw});
      read_and_check("t2 status", REG_ARM, 32'd0);
      read_and_check("t2 source", REG_TRIG_SRC, 32'd0);
      bus_read({12'h0, REG_WP_CUR}, wpc, lat);
      bus_read({12'h0, REG_WP_TRIG}, wpt, lat);
      check_value("t2 pointer distance", 32'(n_dly & PTR_MASK), (wpc - wpt) & PTR_MASK);
      report_test("t2 software trigger");

      check_run("t3", ptr_t'(wpc), 1, 1'b1);
      report_test("t3 buffer contents");

      bus_write(REG_DEC, 32'd4);
      bus_write(REG_DEC_SHF, 32'd2);
      bus_write(REG_AVG_EN, 32'd1);
      bus_write(REG_POST_DLY, 32'd16 + rand_bits(5));
      load_ramp(sample_t'(int'(rand_bits(8)) - 4000));
      bus_write(REG_ARM, 32'd1);
      bus_write(REG_TRIG_SRC, 32'(SRC_SW));
      wait_capture_end(saw);
      bus_read({12'h0, REG_WP_CUR}, wpc, lat);
      check_run("t4", ptr_t'(wpc), 4, 1'b0);    // mean of 4 ramp samples
      report_test("t4 averaging");

      bus_write(REG_DEC, 32'd1);
      bus_write(REG_AVG_EN, 32'd0);
      bus_write(REG_POST_DLY, 32'd32);
      thr = sample_t'(int'(rand_bits(12)) - 2048);
      bus_write(REG_THR_A, 32'(thr));
      bus_write(REG_HYST_A, 32'd20);
      load_ramp(thr - 14'sd150 - sample_t'(rand_bits(6)));
      bus_write(REG_ARM, 32'd1);
      bus_write(REG_TRIG_SRC, 32'(SRC_A_POS));
      wait_capture_end(saw);
      bus_read({12'h0, REG_WP_TRIG}, wpt, lat);
      read_buf(BUF_A_REGION, ptr_t'(wpt), ent);
      check_value("t5 trigger entry", nearest_in(int'(ent), int'(thr), int'(thr) + 8),
                  32'(int'(ent)));
      report_test("t5 channel A rising");

      thr = sample_t'(int'(rand_bits(12)) - 2048);
      bus_write(REG_THR_B, 32'(thr));
      bus_write(REG_HYST_B, 32'd20);
      load_ramp(-(thr + 14'sd150 + sample_t'(rand_bits(6))));  // B starts above
      bus_write(REG_ARM, 32'd1);
      bus_write(REG_TRIG_SRC, 32'(SRC_B_NEG));
      wait_capture_end(saw);
      bus_read({12'h0, REG_WP_TRIG}, wpt, lat);
      read_buf(BUF_B_REGION, ptr_t'(wpt), ent);
      check_value("t6 trigger entry", nearest_in(int'(ent), int'(thr) - 8, int'(thr)),
                  32'(int'(ent)));
      bus_write(REG_TRIG_SRC, 32'(SRC_NONE));
      bus_write(REG_ARM, 32'd1);
      t0 = cyc;
      while (cyc - t0 < 200) begin
         bus_read({12'h0, REG_ARM}, v, lat);
         check_value("t6 still writing", 32'd1, v & 32'h1);
      end
      bus_write(REG_ARM, 32'd2);                // reset bit
      read_and_check("t6 status after reset", REG_ARM, 32'd0);
      read_and_check("t6 wp_cur after reset", REG_WP_CUR, 32'd0);
      report_test("t6 channel B falling and no trigger");

      $display("tests 6, checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: filelist.f
scope_pkg.sv
scope_regs.sv
dec_avg.sv
level_trig.sv
acq_fsm.sv
post_dly_cnt.sv
capture_buf.sv
scope_top.sv
tb_scope.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert -Wno-fatal
TB_TOP    = tb_scope
RTL_TOP   = scope_top
FILELIST  = filelist.f
OBJ       = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TB_TOP) > $(LOG) 2>&1; st=$$?; cat $(LOG); exit $$st
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ) $(LOG)
